// File: include/pkt_params.svh
`ifndef PKT_PARAMS_SVH
`define PKT_PARAMS_SVH

// width of data and control words.
`define DATA_WIDTH 32

// the length field is clog2 of this, so the longest payload is one less.
`define DATA_LENGTH_MAX 64

`endif

// File: design/pkt_switch_pkg.sv
`include "pkt_params.svh"

package pkt_switch_pkg;

    localparam int DATA_WIDTH      = `DATA_WIDTH;
    localparam int DATA_LENGTH_MAX = `DATA_LENGTH_MAX;

    // length field sits in the low bits of the control word.
    localparam int WIDTH_LENGTH    = $clog2(DATA_LENGTH_MAX);

    typedef logic [DATA_WIDTH-1:0]   word_t;
    typedef logic [WIDTH_LENGTH-1:0] len_t;

    // one entry per filed packet.
    typedef struct packed {
        word_t ctrl;
        len_t  count;
        logic  bad;
    } pkt_desc_t;

endpackage

// File: design/pkt_fifo.sv
`timescale 1ns/100ps

module pkt_fifo #(
    parameter int  DEPTH   = 8,
    parameter type entry_t = logic [31:0]
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  entry_t                     wdata,
    input  logic                       pop,
    output entry_t                     rdata,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] level
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LW = $clog2(DEPTH + 1);

    entry_t        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (level == '0);
    assign full  = (level == LW'(DEPTH));

    // the head entry is visible whenever the FIFO is not empty.
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: level <= level + 1'b1;
                2'b01: level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

// File: design/in_wr_controller.sv
`timescale 1ns/100ps

module in_wr_controller
    import pkt_switch_pkg::*;
#(
    parameter int DATA_DEPTH = 128
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            sop,
    input  logic                            valid,
    input  logic                            eop,
    input  word_t                           ctrl_data_in,
    input  word_t                           data_in,
    input  logic [$clog2(DATA_DEPTH+1)-1:0] data_level,
    input  logic                            desc_full,
    output logic                            in_ready,
    output logic                            data_push,
    output word_t                           data_word,
    output logic                            desc_push,
    output pkt_desc_t                       desc,
    output logic                            done,
    output logic                            error
);

    typedef enum logic [2:0] {
        IDLE  = 3'b110,
        LOAD  = 3'b001,
        WR    = 3'b011,
        WAIT  = 3'b010,
        ERROR = 3'b111
    } state_t;

    state_t state;
    state_t state_n;
    word_t  ctrl_reg;
    len_t   cnt;
    len_t   cnt_next;
    len_t   data_length;
    logic   bad;
    logic   space_ok;
    logic   cnt_full;
    logic   beat;
    logic   last_beat;
    logic   len_mismatch;
    logic   cnt_clr;
    logic   ctrl_load;

    // room for a full-size packet must exist before a new one starts.
    assign space_ok = (DATA_DEPTH - int'(data_level)) >= DATA_LENGTH_MAX;
    assign in_ready = (state == IDLE) && space_ok && !desc_full;

    assign data_length = ctrl_reg[WIDTH_LENGTH-1:0];
    assign cnt_full    = (cnt == '1);
    assign beat        = (state == WR) && valid;
    assign last_beat   = beat && eop;

    // a beat past the largest count is not stored and marks the packet bad.
    assign data_push = beat && !cnt_full;
    assign data_word = data_in;
    assign cnt_next  = data_push ? cnt + 1'b1 : cnt;

    assign len_mismatch = cnt_full || (cnt_next != data_length);

    assign desc.ctrl  = ctrl_reg;
    assign desc.count = cnt;
    assign desc.bad   = bad;

    assign error = (state == ERROR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            bad <= 1'b0;
        end else begin
            if (cnt_clr) begin
                cnt <= '0;
                bad <= 1'b0;
            end else begin
                cnt <= cnt_next;
                if (last_beat) begin
                    bad <= len_mismatch;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_load) begin
            ctrl_reg <= ctrl_data_in;
        end
    end

    always_comb begin
        state_n   = state;
        ctrl_load = 1'b0;
        cnt_clr   = 1'b0;
        desc_push = 1'b0;
        done      = 1'b0;
        case (state)
            IDLE: begin
                if (sop && in_ready) begin
                    state_n = LOAD;
                end
            end
            LOAD: begin
                ctrl_load = 1'b1;
                cnt_clr   = 1'b1;
                state_n   = WR;
            end
            WR: begin
                if (last_beat) begin
                    state_n = len_mismatch ? ERROR : WAIT;
                end
            end
            ERROR: begin
                state_n = WAIT;
            end
            WAIT: begin
                // file the descriptor as soon as there is room for it.
                if (!desc_full) begin
                    desc_push = 1'b1;
                    done      = 1'b1;
                    state_n   = IDLE;
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

endmodule

// File: design/out_rd_controller.sv
`timescale 1ns/100ps

module out_rd_controller
    import pkt_switch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      desc_empty,
    input  pkt_desc_t desc,
    output logic      desc_pop,
    input  logic      data_empty,
    input  word_t     data_word,
    output logic      data_pop,
    input  logic      out_ready,
    output logic      out_valid,
    output logic      out_sop,
    output logic      out_eop,
    output word_t     out_data
);

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        HEAD = 2'b01,
        SEND = 2'b10,
        DROP = 2'b11
    } state_t;

    state_t state;
    state_t state_n;
    len_t   rem;
    logic   rem_load;
    logic   send_ctrl;
    logic   send_data;
    logic   send_last;

    always_comb begin
        state_n   = state;
        rem_load  = 1'b0;
        send_ctrl = 1'b0;
        send_data = 1'b0;
        send_last = 1'b0;
        data_pop  = 1'b0;
        desc_pop  = 1'b0;
        case (state)
            IDLE: begin
                if (!desc_empty) begin
                    rem_load = 1'b1;
                    state_n  = desc.bad ? DROP : HEAD;
                end
            end
            HEAD: begin
                if (out_ready) begin
                    send_ctrl = 1'b1;
                    state_n   = SEND;
                end
            end
            SEND: begin
                if (out_ready && !data_empty) begin
                    send_data = 1'b1;
                    data_pop  = 1'b1;
                    if (rem == len_t'(1)) begin
                        send_last = 1'b1;
                        desc_pop  = 1'b1;
                        state_n   = IDLE;
                    end
                end
            end
            DROP: begin
                // drain without looking at out_ready.
                if (rem == '0) begin
                    desc_pop = 1'b1;
                    state_n  = IDLE;
                end else if (!data_empty) begin
                    data_pop = 1'b1;
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            rem       <= '0;
            out_valid <= 1'b0;
            out_sop   <= 1'b0;
            out_eop   <= 1'b0;
        end else begin
            state     <= state_n;
            out_valid <= send_ctrl || send_data;
            out_sop   <= send_ctrl;
            out_eop   <= send_last;
            if (rem_load) begin
                rem <= desc.count;
            end else if (data_pop) begin
                rem <= rem - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send_ctrl) begin
            out_data <= desc.ctrl;
        end else if (send_data) begin
            out_data <= data_word;
        end
    end

endmodule

// File: design/pkt_ingress_top.sv
`timescale 1ns/100ps

module pkt_ingress_top
    import pkt_switch_pkg::*;
#(
    parameter int DATA_DEPTH = 128,
    parameter int DESC_DEPTH = 8
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  sop,
    input  word_t ctrl_data_in,
    input  logic  valid,
    input  word_t data_in,
    input  logic  eop,
    output logic  in_ready,
    input  logic  out_ready,
    output logic  out_valid,
    output logic  out_sop,
    output logic  out_eop,
    output word_t out_data,
    output logic  done,
    output logic  error
);

    logic                            data_push;
    word_t                           data_wr;
    logic                            data_pop;
    word_t                           data_head;
    logic                            data_empty;
    logic [$clog2(DATA_DEPTH+1)-1:0] data_level;
    logic                            desc_push;
    pkt_desc_t                       desc_wr;
    logic                            desc_pop;
    pkt_desc_t                       desc_head;
    logic                            desc_empty;
    logic                            desc_full;

    in_wr_controller #(
        .DATA_DEPTH (DATA_DEPTH)
    ) in_wr_controller_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .sop          (sop),
        .valid        (valid),
        .eop          (eop),
        .ctrl_data_in (ctrl_data_in),
        .data_in      (data_in),
        .data_level   (data_level),
        .desc_full    (desc_full),
        .in_ready     (in_ready),
        .data_push    (data_push),
        .data_word    (data_wr),
        .desc_push    (desc_push),
        .desc         (desc_wr),
        .done         (done),
        .error        (error)
    );

    pkt_fifo #(
        .DEPTH   (DATA_DEPTH),
        .entry_t (word_t)
    ) data_fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (data_push),
        .wdata (data_wr),
        .pop   (data_pop),
        .rdata (data_head),
        .empty (data_empty),
        .full  (),
        .level (data_level)
    );

    pkt_fifo #(
        .DEPTH   (DESC_DEPTH),
        .entry_t (pkt_desc_t)
    ) desc_fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (desc_push),
        .wdata (desc_wr),
        .pop   (desc_pop),
        .rdata (desc_head),
        .empty (desc_empty),
        .full  (desc_full),
        .level ()
    );

    out_rd_controller out_rd_controller_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .desc_empty (desc_empty),
        .desc       (desc_head),
        .desc_pop   (desc_pop),
        .data_empty (data_empty),
        .data_word  (data_head),
        .data_pop   (data_pop),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_sop    (out_sop),
        .out_eop    (out_eop),
        .out_data   (out_data)
    );

endmodule

// File: verification/pkt_ingress_tb.sv
`timescale 1ns/100ps

module pkt_ingress_tb
    import pkt_switch_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_PACKETS = 60;
    localparam int DATA_DEPTH  = 128;
    localparam int DESC_DEPTH  = 8;
    localparam int LONG_STALL  = 800;
    localparam int STALL_TAIL  = 200;
    // stalls may stretch a packet to four times its nominal slot.
    localparam int TIMEOUT_NS  = NUM_PACKETS * (DATA_LENGTH_MAX + 16) * 4 * CLK_PERIOD;
    // everything still buffered after the last descriptor must leave within this.
    localparam int DRAIN_CYCLES = 4 * (DATA_DEPTH + DESC_DEPTH);

    typedef word_t word_q_t[$];

    logic  clk;
    logic  rst_n;
    logic  sop;
    word_t ctrl_data_in;
    logic  valid;
    word_t data_in;
    logic  eop;
    logic  in_ready;
    logic  out_ready;
    logic  out_valid;
    logic  out_sop;
    logic  out_eop;
    word_t out_data;
    logic  done;
    logic  error;

    word_t exp_words[$];
    bit    exp_sop[$];
    bit    exp_eop[$];
    int    packets_sent;
    int    lie_count;
    int    done_count;
    int    error_count;
    bit    stall_watch;
    bit    long_stall_done;

    pkt_ingress_top #(
        .DATA_DEPTH (DATA_DEPTH),
        .DESC_DEPTH (DESC_DEPTH)
    ) pkt_ingress_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .sop          (sop),
        .ctrl_data_in (ctrl_data_in),
        .valid        (valid),
        .data_in      (data_in),
        .eop          (eop),
        .in_ready     (in_ready),
        .out_ready    (out_ready),
        .out_valid    (out_valid),
        .out_sop      (out_sop),
        .out_eop      (out_eop),
        .out_data     (out_data),
        .done         (done),
        .error        (error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // a packet whose beat count misses its length field is dropped entirely.
    function automatic word_q_t expected_words(input word_t ctrl, input word_q_t payload);
        word_q_t words;
        if (payload.size() == int'(ctrl[WIDTH_LENGTH-1:0])) begin
            words.push_back(ctrl);
            foreach (payload[i]) begin
                words.push_back(payload[i]);
            end
        end
        return words;
    endfunction

    // called at a falling edge, returns at a falling edge.
    task automatic send_packet(input int len_field, input int beats);
        word_t   ctrl;
        word_q_t payload;
        word_q_t words;
        int      gaps;
        ctrl = $urandom();
        ctrl[WIDTH_LENGTH-1:0] = len_field[WIDTH_LENGTH-1:0];
        for (int i = 0; i < beats; i++) begin
            payload.push_back($urandom());
        end
        words = expected_words(ctrl, payload);
        foreach (words[i]) begin
            exp_words.push_back(words[i]);
            exp_sop.push_back(i == 0);
            exp_eop.push_back(i == words.size() - 1);
        end
        while (!in_ready) begin
            @(negedge clk);
        end
        sop = 1'b1;
        @(negedge clk);
        sop = 1'b0;
        ctrl_data_in = ctrl;
        packets_sent++;
        @(negedge clk);
        ctrl_data_in = $urandom();
        for (int i = 0; i < beats; i++) begin
            gaps = ($urandom_range(3) == 0) ? $urandom_range(3, 1) : 0;
            repeat (gaps) begin
                valid   = 1'b0;
                eop     = 1'b0;
                data_in = $urandom();
                @(negedge clk);
            end
            valid   = 1'b1;
            data_in = payload[i];
            eop     = (i == beats - 1);
            @(negedge clk);
        end
        valid = 1'b0;
        eop   = 1'b0;
        @(negedge clk);
    endtask

    initial begin : stimulus
        int len_field;
        int beats;
        bit lie;
        int drain;
        void'($urandom(32'h3399_004c));
        rst_n           = 1'b0;
        sop             = 1'b0;
        ctrl_data_in    = '0;
        valid           = 1'b0;
        data_in         = '0;
        eop             = 1'b0;
        out_ready       = 1'b0;
        packets_sent    = 0;
        lie_count       = 0;
        stall_watch     = 1'b0;
        long_stall_done = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_value("out_valid", out_valid, 1'b0);
        check_value("done", done, 1'b0);
        check_value("error", error, 1'b0);
        check_value("in_ready", in_ready, 1'b1);
        for (int n = 0; n < NUM_PACKETS; n++) begin
            len_field = $urandom_range(DATA_LENGTH_MAX - 1, 1);
            lie       = ($urandom_range(4) == 0);
            beats     = len_field;
            if (lie) begin
                lie_count++;
                if (len_field == 1) begin
                    beats = 2;
                end else if (len_field == DATA_LENGTH_MAX - 1) begin
                    beats = len_field - 1;
                end else begin
                    beats = $urandom_range(1) ? len_field + 1 : len_field - 1;
                end
            end
            send_packet(len_field, beats);
        end
        while (done_count != NUM_PACKETS) begin
            @(negedge clk);
        end
        drain = 0;
        while (exp_words.size() != 0 && drain < DRAIN_CYCLES) begin
            @(negedge clk);
            drain++;
        end
        // a few idle cycles catch stray output beats.
        repeat (20) @(negedge clk);
        check_value("done pulse count", done_count, NUM_PACKETS);
        check_value("error pulse count", error_count, lie_count);
        check_value("long stall phase", long_stall_done, 1'b1);
        if (exp_words.size() != 0) begin
            $display("%0d expected words never reached the output", exp_words.size());
            abort_run();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    // random ready phases, plus one long stall once traffic is flowing.
    initial begin : backpressure
        wait (rst_n === 1'b1);
        forever begin
            if (!long_stall_done && packets_sent >= 5) begin
                out_ready = 1'b0;
                repeat (LONG_STALL - STALL_TAIL) @(negedge clk);
                stall_watch = 1'b1;
                repeat (STALL_TAIL) @(negedge clk);
                stall_watch     = 1'b0;
                long_stall_done = 1'b1;
            end else begin
                out_ready = ($urandom_range(9) < 7);
                repeat ($urandom_range(12, 1)) @(negedge clk);
            end
        end
    end

    // values read at the rising edge belong to the cycle that just ended.
    initial begin : monitor
        logic prev_ready;
        done_count  = 0;
        error_count = 0;
        prev_ready  = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (done) begin
                    done_count++;
                end
                if (error) begin
                    error_count++;
                end
                if (stall_watch) begin
                    check_value("in_ready", in_ready, 1'b0);
                end
                if (out_valid && !prev_ready) begin
                    check_value("out_valid", out_valid, 1'b0);
                end
                if (out_valid) begin
                    if (exp_words.size() == 0) begin
                        $display("output beat %0h at %0t with no packet pending", out_data, $time);
                        abort_run();
                    end else begin
                        check_value("out_data", out_data, exp_words.pop_front());
                        check_value("out_sop", out_sop, exp_sop.pop_front());
                        check_value("out_eop", out_eop, exp_eop.pop_front());
                    end
                end
            end
            prev_ready = out_ready;
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, %0d of %0d packets sent, %0d words still expected",
                 TIMEOUT_NS, packets_sent, NUM_PACKETS, exp_words.size());
        abort_run();
    end

endmodule

// File: project.f
+incdir+include
design/pkt_switch_pkg.sv
design/pkt_fifo.sv
design/in_wr_controller.sv
design/out_rd_controller.sv
design/pkt_ingress_top.sv
verification/pkt_ingress_tb.sv

// File: Bender.yml
package:
  name: pkt_ingress

dependencies: {}

export_include_dirs:
  - include

sources:
  # synthesizable design, package first.
  - include_dirs:
      - include
    files:
      - design/pkt_switch_pkg.sv
      - design/pkt_fifo.sv
      - design/in_wr_controller.sv
      - design/out_rd_controller.sv
      - design/pkt_ingress_top.sv

  # testbench, only for simulation.
  - target: simulation
    files:
      - verification/pkt_ingress_tb.sv
